//--- bench/mem_subsystem_asserts.sv
`default_nettype none

module mem_subsystem_asserts
    import lsu_pkg::*;
(
    input wire                 clk,
    input wire                 rst,
    input wire                 fetch_valid,
    input wire                 fetch_full,
    input wire                 dispatch_valid,
    input wire [TAG_W-1:0]     dispatch_tag,
    input wire [LSB_DEPTH-1:0] busy,
    input wire                 mem_done,
    input wire                 ins_done,
    input wire                 ram_we
);
    timeunit 1ns;
    timeprecision 1ps;

    // Producer must respect the early full flag
    a_push_while_full: assert property (@(posedge clk) disable iff (!rst)
        fetch_valid |-> !fetch_full)
        else $error("fetch push while fetch_full is high");

    a_dispatch_busy: assert property (@(posedge clk) disable iff (!rst)
        (dispatch_valid && dispatch_tag != '0) |-> !busy[dispatch_tag])
        else $error("dispatch to a busy tag");

    a_done_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(mem_done && ins_done))
        else $error("mem_done and ins_done high together");

    // First cycle out of reset
    a_we_after_reset: assert property (@(posedge clk)
        $rose(rst) |-> !ram_we)
        else $error("RAM write enable high after reset");

endmodule

bind mem_subsystem mem_subsystem_asserts u_asserts (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_full     (fetch_full),
    .dispatch_valid (dispatch_valid),
    .dispatch_tag   (dispatch_tag),
    .busy           (u_lsb.busy),
    .mem_done       (mem_done),
    .ins_done       (ins_done),
    .ram_we         (ram_cmd.we)
);

`default_nettype wire

//--- bench/mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb
    import lsu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    logic             clk;
    logic             rst;
    logic             dispatch_valid;
    logic [TAG_W-1:0] dispatch_tag;
    lsb_entry_t       dispatch_entry;
    logic [TAG_W-1:0] commit_tag;
    logic             fetch_valid;
    logic [31:0]      fetch_pc;
    logic             fetch_full;
    logic             mem_done;
    mem_result_t      mem_result;
    logic             ins_done;
    logic [31:0]      ins_value;

    logic [31:0]  lfsr_state = 32'hcedb1a49;
    logic [7:0]   shadow [2**RAM_AW];
    mem_op_e      ent_op   [LSB_DEPTH];
    logic [31:0]  ent_addr [LSB_DEPTH];
    logic [31:0]  ent_data [LSB_DEPTH];
    mem_result_t  mem_exp [$];
    logic [31:0]  ins_exp [$];
    int           mem_errs = 0;
    int           ins_errs = 0;
    int           misc_errs = 0;
    logic         saw_full;

    mem_subsystem UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Little-endian byte gather with RV32I extension rules
    function automatic logic [31:0] ref_load(input mem_op_e op, input logic [31:0] addr);
        logic [RAM_AW-1:0] a;
        logic [31:0]       w;
        a = addr[RAM_AW-1:0];
        w = {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
        case (op)
            LB:      return {{24{w[7]}}, w[7:0]};
            LBU:     return {24'h0, w[7:0]};
            LH:      return {{16{w[15]}}, w[15:0]};
            LHU:     return {16'h0, w[15:0]};
            LW:      return w;
            default: return 32'h0;
        endcase
    endfunction

    function automatic void shadow_store(input mem_op_e op, input logic [31:0] addr,
                                         input logic [31:0] data);
        int n;
        n = (op == SB) ? 1 : (op == SH) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            shadow[RAM_AW'(addr[RAM_AW-1:0] + i)] = data[i*8 +: 8];
        end
    endfunction

    function automatic logic [31:0] data_addr(input logic [5:0] word, input logic [1:0] ofs);
        return {20'(rand_bits(20)), 4'h0, word, ofs};
    endfunction

    function automatic logic [31:0] code_addr();
        return {20'(rand_bits(20)), 4'h4, 6'(rand_bits(6)), 2'b00};
    endfunction

    task automatic dispatch(input logic [TAG_W-1:0] tag, input mem_op_e op,
                            input logic [31:0] addr, input logic [31:0] data);
        ent_op[tag]   = op;
        ent_addr[tag] = addr;
        ent_data[tag] = data;
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch_tag   <= tag;
        dispatch_entry <= '{op: op, addr: addr, data: data};
        @(posedge clk);
        dispatch_valid <= 1'b0;
    endtask

    // Commit order is completion order, so the shadow is updated here
    task automatic commit(input logic [TAG_W-1:0] tag);
        if (ent_op[tag] inside {SB, SH, SW}) begin
            shadow_store(ent_op[tag], ent_addr[tag], ent_data[tag]);
            mem_exp.push_back('{tag: tag, value: 32'h0});
        end else begin
            mem_exp.push_back('{tag: tag, value: ref_load(ent_op[tag], ent_addr[tag])});
        end
        @(posedge clk);
        commit_tag <= tag;
        @(posedge clk);
        commit_tag <= '0;
    endtask

    task automatic do_mem(input logic [TAG_W-1:0] tag, input mem_op_e op,
                          input logic [31:0] addr, input logic [31:0] data);
        dispatch(tag, op, addr, data);
        commit(tag);
    endtask

    task automatic push_fetch(input logic [31:0] addr);
        int n;
        n = 0;
        @(negedge clk);
        while (fetch_full) begin
            n++;
            if (n > 200) begin
                $display("Timeout: fetch_full never fell");
                $display("SIMULATION FAILED");
                $finish;
            end
            @(negedge clk);
        end
        ins_exp.push_back(ref_load(LW, addr));
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_pc    <= addr;
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (mem_exp.size() != 0 || ins_exp.size() != 0) begin
            n++;
            if (n > 2000) begin
                $display("Timeout: %0d memory and %0d fetch results missing",
                         mem_exp.size(), ins_exp.size());
                $display("SIMULATION FAILED");
                $finish;
            end
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        mem_result_t e;
        logic [31:0] w;
        if (fetch_full) begin
            saw_full = 1'b1;
        end
        if (mem_done) begin
            if (mem_exp.size() == 0) begin
                $display("mem_done pulsed with no operation outstanding at %0t", $time);
                misc_errs++;
            end else begin
                e = mem_exp.pop_front();
                if (mem_result !== e) begin
                    $display("[FAIL] %0t: mem tag %0d value %h, expected tag %0d value %h",
                             $time, mem_result.tag, mem_result.value, e.tag, e.value);
                    mem_errs++;
                end
            end
        end
        if (ins_done) begin
            if (ins_exp.size() == 0) begin
                $display("ins_done pulsed with no fetch outstanding at %0t", $time);
                misc_errs++;
            end else begin
                w = ins_exp.pop_front();
                if (ins_value !== w) begin
                    $display("[FAIL] %0t: fetch word %h, expected %h", $time, ins_value, w);
                    ins_errs++;
                end
            end
        end
    end

    initial begin
        logic [31:0] a;
        logic [TAG_W-1:0] t;
        mem_op_e op;
        rst            = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_tag   = '0;
        dispatch_entry = '0;
        commit_tag     = '0;
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        saw_full       = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        if (fetch_full !== 1'b0 || mem_done !== 1'b0 || ins_done !== 1'b0) begin
            $display("[FAIL] %0t: outputs not idle after reset", $time);
            misc_errs++;
        end

        // Fill data and code regions with an address-derived pattern
        for (int i = 0; i < 128; i++) begin
            a = (i < 64) ? 32'(i * 4) : 32'h400 + 32'((i - 64) * 4);
            do_mem(TAG_W'(i % 7 + 1), SW, a, {~a[15:0], a[15:0] ^ 16'h5a3c});
            wait_drain();
        end

        // Word store then load with different upper address bits
        for (int i = 0; i < 8; i++) begin
            a = data_addr(6'(rand_bits(6)), 2'b00);
            t = TAG_W'(rand_bits(2) + 1);
            do_mem(t, SW, a, rand_bits(32));
            wait_drain();
            do_mem(t + 3'd1, LW, {20'(rand_bits(20)), a[11:0]}, 32'h0);
            wait_drain();
        end

        // Sub-word stores and extending loads that overlap them
        for (int i = 0; i < 8; i++) begin
            a = data_addr(6'(rand_bits(6)), 2'b00);
            do_mem(3'd1, SB, a + rand_bits(2), rand_bits(32));
            do_mem(3'd2, SH, a + 2 * rand_bits(1), rand_bits(32));
            do_mem(3'd3, LB, a + rand_bits(2), 32'h0);
            do_mem(3'd4, LBU, a + rand_bits(2), 32'h0);
            do_mem(3'd5, LH, a + 2 * rand_bits(1), 32'h0);
            do_mem(3'd6, LHU, a + 2 * rand_bits(1), 32'h0);
            wait_drain();
        end

        // Back-to-back fetches fill the queue and wrap its pointers
        saw_full = 1'b0;
        for (int i = 0; i < 12; i++) begin
            push_fetch(code_addr());
        end
        wait_drain();
        @(negedge clk);
        if (!saw_full) begin
            $display("fetch_full never rose during the fetch burst");
            misc_errs++;
        end
        if (fetch_full) begin
            $display("fetch_full still high after the queue drained");
            misc_errs++;
        end

        // Uncommitted store must stay invisible to fetch
        a = code_addr();
        dispatch(3'd3, SW, a, rand_bits(32));
        push_fetch(a);
        wait_drain();
        commit(3'd3);
        wait_drain();
        push_fetch(a);
        wait_drain();

        // Seven operations committed in one burst with fetches waiting
        for (int i = 1; i < LSB_DEPTH; i++) begin
            op = mem_op_e'(rand_bits(3));
            dispatch(TAG_W'(i), op, data_addr(6'(rand_bits(6)), 2'b00), rand_bits(32));
        end
        for (int i = 0; i < 4; i++) begin
            push_fetch(code_addr());
        end
        for (int i = 1; i < LSB_DEPTH; i++) begin
            commit(TAG_W'(i));
        end
        wait_drain();
        repeat (4) @(posedge clk);

        $display("Errors: memory %0d, fetch %0d, other %0d", mem_errs, ins_errs, misc_errs);
        if (mem_errs + ins_errs + misc_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // Reorder-buffer tag, also the buffer index
    localparam int TAG_W = 3;

    // Entry 0 is reserved for "no operation"
    localparam int LSB_DEPTH = 8;

    // Fetch queue geometry
    localparam int FQ_DEPTH = 8;
    localparam int FQ_PTR_W = $clog2(FQ_DEPTH);
    localparam int FQ_CNT_W = FQ_PTR_W + 1;

    // Two or fewer free slots counts as full
    localparam int FQ_FULL_AT = FQ_DEPTH - 2;

    // Byte RAM address width, upper address bits are dropped
    localparam int RAM_AW = 12;

    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } mem_op_e;

    // One dispatched memory operation
    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] data;
    } lsb_entry_t;

    // Committed operation handed to the sequencer
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        lsb_entry_t       entry;
    } mem_req_t;

    // Completion of a load or store
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      value;
    } mem_result_t;

    // Byte RAM command
    typedef struct packed {
        logic [RAM_AW-1:0] addr;
        logic              we;
        logic [7:0]        wdata;
    } ram_cmd_t;

endpackage

`default_nettype wire

//--- design/byte_ram.sv
`default_nettype none

module byte_ram
    import lsu_pkg::*;
(
    input  wire            clk,
    input  wire ram_cmd_t  ram_cmd,
    output logic [7:0]     rdata
);

    logic [7:0] mem [2**RAM_AW];

    always_ff @(posedge clk) begin
        if (ram_cmd.we) begin
            mem[ram_cmd.addr] <= ram_cmd.wdata;
        end
        // Read-first on a same-address write
        rdata <= mem[ram_cmd.addr];
    end

endmodule

`default_nettype wire

//--- design/fetch_queue.sv
`default_nettype none

module fetch_queue
    import lsu_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         push,
    input  wire [31:0]  push_pc,
    input  wire         pop,
    output logic        head_valid,
    output logic [31:0] head_pc,
    output logic        full
);

    logic [31:0] pc_mem [FQ_DEPTH];

    logic [FQ_PTR_W-1:0] head;
    logic [FQ_PTR_W-1:0] tail;
    logic [FQ_CNT_W-1:0] count;
    logic [FQ_CNT_W-1:0] count_next;
    logic                do_push;
    logic                do_pop;

    // Pushes beyond the last slot are dropped
    assign do_push = push && (count != FQ_CNT_W'(FQ_DEPTH));
    assign do_pop  = pop && head_valid;

    assign head_valid = (count != '0);
    assign head_pc    = pc_mem[head];

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[tail] <= push_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            full  <= 1'b0;
        end else begin
            // Pointers wrap on the power-of-two depth
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            count <= count_next;
            // Raised early to leave the producer a cycle of slack
            full  <= (count_next >= FQ_CNT_W'(FQ_FULL_AT));
        end
    end

endmodule

`default_nettype wire

//--- design/mem_subsystem.sv
`default_nettype none

module mem_subsystem
    import lsu_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 dispatch_valid,
    input  wire [TAG_W-1:0]     dispatch_tag,
    input  wire lsb_entry_t     dispatch_entry,
    input  wire [TAG_W-1:0]     commit_tag,
    input  wire                 fetch_valid,
    input  wire [31:0]          fetch_pc,
    output logic                fetch_full,
    output logic                mem_done,
    output mem_result_t         mem_result,
    output logic                ins_done,
    output logic [31:0]         ins_value
);

    logic        issue_valid;
    logic        issue_take;
    mem_req_t    issue_req;
    logic        fq_valid;
    logic [31:0] fq_pc;
    logic        fetch_take;
    ram_cmd_t    ram_cmd;
    logic [7:0]  ram_rdata;

    lsb_buffer u_lsb (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_tag   (dispatch_tag),
        .dispatch_entry (dispatch_entry),
        .commit_tag     (commit_tag),
        .issue_take     (issue_take),
        .issue_valid    (issue_valid),
        .issue_req      (issue_req)
    );

    fetch_queue u_fq (
        .clk        (clk),
        .rst        (rst),
        .push       (fetch_valid),
        .push_pc    (fetch_pc),
        .pop        (fetch_take),
        .head_valid (fq_valid),
        .head_pc    (fq_pc),
        .full       (fetch_full)
    );

    mem_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .issue_take  (issue_take),
        .fq_valid    (fq_valid),
        .fq_pc       (fq_pc),
        .fetch_take  (fetch_take),
        .ram_cmd     (ram_cmd),
        .ram_rdata   (ram_rdata),
        .mem_done    (mem_done),
        .mem_result  (mem_result),
        .ins_done    (ins_done),
        .ins_value   (ins_value)
    );

    byte_ram u_ram (
        .clk     (clk),
        .ram_cmd (ram_cmd),
        .rdata   (ram_rdata)
    );

endmodule

`default_nettype wire

//--- load_store/lsb_buffer.sv
`default_nettype none

module lsb_buffer
    import lsu_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  dispatch_valid,
    input  wire [TAG_W-1:0]      dispatch_tag,
    input  wire lsb_entry_t      dispatch_entry,
    input  wire [TAG_W-1:0]      commit_tag,
    input  wire                  issue_take,
    output logic                 issue_valid,
    output mem_req_t             issue_req
);

    lsb_entry_t entry_q [LSB_DEPTH];

    logic [LSB_DEPTH-1:0] busy;
    logic [LSB_DEPTH-1:0] committed;
    logic [LSB_DEPTH-1:0] ready;
    logic [TAG_W-1:0]     sel_tag;
    logic                 dispatch_hit;
    logic                 commit_hit;

    // Tag 0 carries no operation
    assign dispatch_hit = dispatch_valid && (dispatch_tag != '0);
    assign commit_hit   = (commit_tag != '0);

    assign ready = busy & committed;

    // Lowest ready tag wins
    always_comb begin
        sel_tag = '0;
        for (int i = LSB_DEPTH - 1; i > 0; i--) begin
            if (ready[i]) begin
                sel_tag = TAG_W'(i);
            end
        end
    end

    assign issue_valid = |ready;
    assign issue_req   = '{tag: sel_tag, entry: entry_q[sel_tag]};

    always_ff @(posedge clk) begin
        if (dispatch_hit) begin
            entry_q[dispatch_tag] <= dispatch_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy      <= '0;
            committed <= '0;
        end else begin
            // Issued entry leaves the buffer on the take edge
            if (issue_take) begin
                busy[sel_tag]      <= 1'b0;
                committed[sel_tag] <= 1'b0;
            end

            if (commit_hit) begin
                committed[commit_tag] <= 1'b1;
            end

            // A fresh dispatch starts uncommitted
            if (dispatch_hit) begin
                busy[dispatch_tag]      <= 1'b1;
                committed[dispatch_tag] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- load_store/mem_sequencer.sv
`default_nettype none

module mem_sequencer
    import lsu_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                issue_valid,
    input  wire mem_req_t      issue_req,
    output logic               issue_take,
    input  wire                fq_valid,
    input  wire [31:0]         fq_pc,
    output logic               fetch_take,
    output ram_cmd_t           ram_cmd,
    input  wire [7:0]          ram_rdata,
    output logic               mem_done,
    output mem_result_t        mem_result,
    output logic               ins_done,
    output logic [31:0]        ins_value
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DRAIN,
        S_FINISH
    } state_e;

    state_e            state;
    logic              is_fetch;
    logic              is_store;
    logic [TAG_W-1:0]  cur_tag;
    mem_op_e           cur_op;
    logic [RAM_AW-1:0] base_addr;
    logic [31:0]       wr_data;
    logic [31:0]       rd_data;
    logic [31:0]       load_value;
    logic [1:0]        byte_idx;
    logic [1:0]        last_idx;
    logic              rd_pend;
    logic [1:0]        rd_lane;

    // Index of the final byte for each access size
    function automatic logic [1:0] op_last_idx(input mem_op_e op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            default:     return 2'd3;
        endcase
    endfunction

    assign is_store = (cur_op == SB) || (cur_op == SH) || (cur_op == SW);

    // Committed memory ops go ahead of fetches
    assign issue_take = (state == S_IDLE) && issue_valid;
    assign fetch_take = (state == S_IDLE) && !issue_valid && fq_valid;

    assign ram_cmd = '{
        addr:  base_addr + RAM_AW'(byte_idx),
        we:    (state == S_ADDR) && is_store,
        wdata: wr_data[byte_idx*8 +: 8]
    };

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= S_IDLE;
            is_fetch <= 1'b0;
            byte_idx <= '0;
            rd_pend  <= 1'b0;
        end else begin
            // A read issued now returns next cycle
            rd_pend  <= (state == S_ADDR) && !is_store;
            byte_idx <= (state == S_ADDR) ? byte_idx + 2'd1 : 2'd0;

            case (state)
                S_IDLE: begin
                    if (issue_take) begin
                        state    <= S_ADDR;
                        is_fetch <= 1'b0;
                    end else if (fetch_take) begin
                        state    <= S_ADDR;
                        is_fetch <= 1'b1;
                    end
                end
                S_ADDR: begin
                    if (byte_idx == last_idx) begin
                        // Stores have nothing to wait for
                        state <= is_store ? S_FINISH : S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    state <= S_FINISH;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_take) begin
            cur_tag   <= issue_req.tag;
            cur_op    <= issue_req.entry.op;
            base_addr <= issue_req.entry.addr[RAM_AW-1:0];
            wr_data   <= issue_req.entry.data;
            last_idx  <= op_last_idx(issue_req.entry.op);
        end else if (fetch_take) begin
            // Fetch is a plain word read
            cur_op    <= LW;
            base_addr <= fq_pc[RAM_AW-1:0];
            last_idx  <= op_last_idx(LW);
        end

        rd_lane <= byte_idx;
        if (rd_pend) begin
            rd_data[rd_lane*8 +: 8] <= ram_rdata;
        end
    end

    // Extension of the assembled bytes, stores report zero
    always_comb begin
        case (cur_op)
            LB:      load_value = {{24{rd_data[7]}}, rd_data[7:0]};
            LBU:     load_value = {24'h0, rd_data[7:0]};
            LH:      load_value = {{16{rd_data[15]}}, rd_data[15:0]};
            LHU:     load_value = {16'h0, rd_data[15:0]};
            LW:      load_value = rd_data;
            default: load_value = '0;
        endcase
    end

    assign mem_done   = (state == S_FINISH) && !is_fetch;
    assign ins_done   = (state == S_FINISH) && is_fetch;
    assign mem_result = '{tag: cur_tag, value: load_value};
    assign ins_value  = rd_data;

endmodule

`default_nettype wire

//--- mem_subsystem.f
common/lsu_pkg.sv
load_store/lsb_buffer.sv
load_store/mem_sequencer.sv
design/fetch_queue.sv
design/byte_ram.sv
design/mem_subsystem.sv
bench/mem_subsystem_asserts.sv
bench/mem_subsystem_tb.sv
